//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_ec_point_unit
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Done: no errors

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_ec_point_unit.sv
`timescale 1ns/1ps

module tb_ec_point_unit;

    localparam int max_ops   = 20;
    localparam int op_cycles = 4000;

    logic                 i_clk, i_reset, i_start;
    point_pkg::point_op_e i_point_op;
    field_pkg::field_t    i_x1, i_y1, i_x2, i_y2, i_a;
    logic                 o_busy, o_done;
    field_pkg::field_t    o_x3, o_y3;
    int                   seed = 28;
    int                   errors = 0;
    int                   tests_run = 0;
    int                   tests_failed = 0;

    ec_point_unit ec_point_unit_i (.*);

    function automatic field_pkg::field_t reduce(input logic [63:0] v);
        return field_pkg::field_t'(v % {32'd0, field_pkg::field_prime});
    endfunction

    function automatic field_pkg::field_t add_mod(input field_pkg::field_t a,
                                                  input field_pkg::field_t b);
        return reduce({32'd0, a} + {32'd0, b});
    endfunction

    function automatic field_pkg::field_t sub_mod(input field_pkg::field_t a,
                                                  input field_pkg::field_t b);
        return reduce({32'd0, a} + {32'd0, field_pkg::field_prime} - {32'd0, b});
    endfunction

    function automatic field_pkg::field_t mul_mod(input field_pkg::field_t a,
                                                  input field_pkg::field_t b);
        return reduce({32'd0, a} * {32'd0, b});
    endfunction

    // b^(p-2), msb first
    function automatic field_pkg::field_t inv_mod(input field_pkg::field_t b);
        field_pkg::field_t r;
        field_pkg::field_t e;
        int                i;
        r = 32'd1;
        e = field_pkg::field_prime - 32'd2;
        for (i = 31; i >= 0; i--)
        begin
            r = mul_mod(r, r);
            if (e[i])
                r = mul_mod(r, b);
        end
        return r;
    endfunction

    task automatic model_point(input point_pkg::point_op_e op,
                               input field_pkg::field_t x1, y1, x2, y2, a,
                               output field_pkg::field_t x3, y3);
        field_pkg::field_t slope;
        if (op == point_pkg::PT_DOUBLE)
        begin
            slope = mul_mod(add_mod(mul_mod(32'd3, mul_mod(x1, x1)), a),
                            inv_mod(add_mod(y1, y1)));
            x3 = sub_mod(mul_mod(slope, slope), add_mod(x1, x1));
        end
        else
        begin
            slope = mul_mod(sub_mod(y2, y1), inv_mod(sub_mod(x2, x1)));
            x3 = sub_mod(sub_mod(mul_mod(slope, slope), x1), x2);
        end
        y3 = sub_mod(mul_mod(slope, sub_mod(x1, x3)), y1);
    endtask

    task automatic check_word(input string name, input field_pkg::field_t got,
                              input field_pkg::field_t exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        assert (got === exp)
        else
        begin
            $display("ERR %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic draw_element(output field_pkg::field_t v);
        v = $random(seed);
        while (v == '0 || v >= field_pkg::field_prime)
            v = $random(seed);
    endtask

    task automatic start_op(input point_pkg::point_op_e op,
                            input field_pkg::field_t x1, y1, x2, y2, a);
        @(negedge i_clk);
        check_flag("o_busy", o_busy, 1'b0);
        i_point_op = op;
        i_x1       = x1;
        i_y1       = y1;
        i_x2       = x2;
        i_y2       = y2;
        i_a        = a;
        i_start    = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        check_flag("o_busy", o_busy, 1'b1);  // one cycle after start
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!o_done && n < op_cycles)
        begin
            @(negedge i_clk);
            n++;
        end
        assert (o_done)
        else
        begin
            $display("o_done did not arrive within %0d cycles", op_cycles);
            errors++;
        end
    endtask

    task automatic run_op(input point_pkg::point_op_e op,
                          input field_pkg::field_t x1, y1, x2, y2, a);
        field_pkg::field_t ex3, ey3;
        model_point(op, x1, y1, x2, y2, a, ex3, ey3);
        start_op(op, x1, y1, x2, y2, a);
        wait_done();
        check_flag("o_busy", o_busy, 1'b0);
        check_word("o_x3", o_x3, ex3);
        check_word("o_y3", o_y3, ey3);
        @(negedge i_clk);
        check_flag("o_done", o_done, 1'b0);  // single-cycle pulse
        check_word("o_x3", o_x3, ex3);
        check_word("o_y3", o_y3, ey3);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - errs_before);
        end
    endtask

    task automatic check_reset_and_start();
        int e0;
        e0 = errors;
        check_flag("o_busy", o_busy, 1'b0);
        check_flag("o_done", o_done, 1'b0);
        run_op(point_pkg::PT_DOUBLE, 32'd5, 32'd1, 32'd9, 32'd4, 32'd2);
        end_test("reset_and_start", e0);
    endtask

    task automatic double_fixed_point();
        int e0;
        e0 = errors;
        run_op(point_pkg::PT_DOUBLE, 32'h1234_5678, 32'h0BAD_F00D,
               32'h0000_0001, 32'h0000_0001, 32'd3);
        end_test("double_fixed", e0);
    endtask

    task automatic add_fixed_points();
        int e0;
        e0 = errors;
        run_op(point_pkg::PT_ADD, 32'h1111_2222, 32'h3333_4444,
               32'h5555_6666, 32'h7777_8888, 32'd7);
        end_test("add_fixed", e0);
    endtask

    task automatic random_ops();
        point_pkg::point_op_e op;
        field_pkg::field_t    x1, y1, x2, y2, a;
        int                   e0, k, r;
        e0 = errors;
        for (k = 0; k < 10; k++)
        begin
            r  = $random(seed);
            op = r[0] ? point_pkg::PT_ADD : point_pkg::PT_DOUBLE;
            draw_element(x1);
            draw_element(y1);
            draw_element(x2);
            draw_element(y2);
            draw_element(a);
            while (x2 == x1)
                draw_element(x2);  // keeps the addition slope defined
            run_op(op, x1, y1, x2, y2, a);
        end
        end_test("random_ops", e0);
    endtask

    task automatic ignore_start_while_busy();
        field_pkg::field_t ex3, ey3;
        int                e0, n, pulses;
        e0 = errors;
        model_point(point_pkg::PT_ADD, 32'h0000_0A0A, 32'h0000_0B0B,
                    32'h0000_0C0C, 32'h0000_0D0D, 32'd1, ex3, ey3);
        start_op(point_pkg::PT_ADD, 32'h0000_0A0A, 32'h0000_0B0B,
                 32'h0000_0C0C, 32'h0000_0D0D, 32'd1);
        i_point_op = point_pkg::PT_DOUBLE;  // second request, must be dropped
        i_x1       = 32'h0000_0099;
        i_y1       = 32'h0000_0077;
        i_start    = 1'b1;
        repeat (3) @(negedge i_clk);
        i_start = 1'b0;
        wait_done();
        check_word("o_x3", o_x3, ex3);
        check_word("o_y3", o_y3, ey3);
        pulses = 0;
        for (n = 0; n < 100; n++)
        begin
            @(negedge i_clk);
            if (o_done)
                pulses++;
            check_flag("o_busy", o_busy, 1'b0);
        end
        assert (pulses == 0)
        else
        begin
            $display("o_done pulsed %0d extra time(s) after one accepted start", pulses);
            errors++;
        end
        end_test("ignore_start", e0);
    endtask

    initial
    begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    initial
    begin
        repeat (16 + max_ops * op_cycles) @(posedge i_clk);
        $display("watchdog: run did not finish within %0d cycles", max_ops * op_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        i_reset    = 1'b1;
        i_start    = 1'b0;
        i_point_op = point_pkg::PT_DOUBLE;
        i_x1       = '0;
        i_y1       = '0;
        i_x2       = '0;
        i_y2       = '0;
        i_a        = '0;
        repeat (16) @(negedge i_clk);
        i_reset = 1'b0;
        @(negedge i_clk);
        check_reset_and_start();
        double_fixed_point();
        add_fixed_points();
        random_ops();
        ignore_start_while_busy();
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- hdl/bit_counter.sv
`timescale 1ns/1ps

module bit_counter (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_load,
    input  logic                i_step,
    output field_pkg::bit_idx_t o_idx,
    output logic                o_last
);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            o_idx <= '0;
        else if (i_load)
            o_idx <= field_pkg::bit_idx_t'(field_pkg::field_w - 1);  // msb first
        else if (i_step && !o_last)
            o_idx <= o_idx - 1'b1;                                   // parks at 0
    end

    assign o_last = (o_idx == '0);

endmodule

//--- hdl/ec_point_unit.sv
`timescale 1ns/1ps

module ec_point_unit (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  point_pkg::point_op_e i_point_op,
    input  field_pkg::field_t    i_x1,
    input  field_pkg::field_t    i_y1,
    input  field_pkg::field_t    i_x2,
    input  field_pkg::field_t    i_y2,
    input  field_pkg::field_t    i_a,
    output logic                 o_busy,
    output logic                 o_done,
    output field_pkg::field_t    o_x3,
    output field_pkg::field_t    o_y3
);

    field_op_if  fop_if ();
    point_ctl_if ctl_if ();

    point_seq_fsm point_seq_fsm_i (
        .i_clk,
        .i_reset,
        .i_start,
        .i_point_op,
        .o_busy,
        .o_done,
        .fop (fop_if.seq),
        .ctl (ctl_if.seq)
    );

    point_regs point_regs_i (
        .i_clk,
        .i_reset,
        .i_x1,
        .i_y1,
        .i_x2,
        .i_y2,
        .i_a,
        .i_result (fop_if.result),
        .ctl      (ctl_if.regs),
        .o_x3,
        .o_y3
    );

    field_alu field_alu_i (
        .i_clk,
        .i_reset,
        .alu (fop_if.alu)
    );

endmodule

//--- hdl/field_alu.sv
`timescale 1ns/1ps

module field_alu (
    input  logic   i_clk,
    input  logic   i_reset,
    field_op_if.alu alu
);

    typedef enum logic [2:0] {PH_IDLE, PH_MUL, PH_SQR, PH_EXPM, PH_FMUL} phase_e;

    phase_e              phase, phase_n;
    field_pkg::field_t   acc, mcand, mplier, base, numer;
    field_pkg::field_t   acc_dbl, acc_next, ld_a, ld_b, fin_val;
    field_pkg::bit_idx_t mul_idx, exp_idx;
    logic                mul_last, exp_last, mul_load, mul_run;
    logic                exp_load, exp_step, exp_bit, accept, fin;

    function automatic field_pkg::field_t mod_add(input field_pkg::field_t a,
                                                  input field_pkg::field_t b);
        logic [field_pkg::field_w:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, field_pkg::field_prime})
            s = s - {1'b0, field_pkg::field_prime};
        return s[field_pkg::field_w-1:0];
    endfunction

    function automatic field_pkg::field_t mod_sub(input field_pkg::field_t a,
                                                  input field_pkg::field_t b);
        logic [field_pkg::field_w:0] d;
        d = {1'b0, a} - {1'b0, b};
        if (d[field_pkg::field_w])
            d = d + {1'b0, field_pkg::field_prime};  // borrow, fold back
        return d[field_pkg::field_w-1:0];
    endfunction

    bit_counter mul_cnt_i (.i_clk, .i_reset, .i_load(mul_load), .i_step(mul_run),
                           .o_idx(mul_idx), .o_last(mul_last));
    bit_counter exp_cnt_i (.i_clk, .i_reset, .i_load(exp_load), .i_step(exp_step),
                           .o_idx(exp_idx), .o_last(exp_last));

    assign accept   = (phase == PH_IDLE) && alu.req && !alu.done;
    assign mul_run  = (phase != PH_IDLE);
    assign exp_bit  = field_pkg::field_inv_exp[exp_idx];
    assign acc_dbl  = mod_add(acc, acc);
    assign acc_next = mplier[mul_idx] ? mod_add(acc_dbl, mcand) : acc_dbl;

    always_comb
    begin
        phase_n  = phase;
        mul_load = 1'b0;
        exp_load = 1'b0;
        exp_step = 1'b0;
        ld_a     = acc_next;
        ld_b     = acc_next;
        fin      = 1'b0;
        fin_val  = acc_next;
        case (phase)
            PH_IDLE:
                if (accept)
                begin
                    case (alu.opcode)
                        field_pkg::FOP_ADD:
                        begin
                            fin     = 1'b1;
                            fin_val = mod_add(alu.op_a, alu.op_b);
                        end
                        field_pkg::FOP_SUB:
                        begin
                            fin     = 1'b1;
                            fin_val = mod_sub(alu.op_a, alu.op_b);
                        end
                        field_pkg::FOP_MUL:
                        begin
                            mul_load = 1'b1;
                            ld_a     = alu.op_a;
                            ld_b     = alu.op_b;
                            phase_n  = PH_MUL;
                        end
                        field_pkg::FOP_DIV:
                        begin
                            mul_load = 1'b1;
                            exp_load = 1'b1;
                            ld_a     = field_pkg::field_t'(1);  // y = 1, squared first
                            ld_b     = field_pkg::field_t'(1);
                            phase_n  = PH_SQR;
                        end
                    endcase
                end
            PH_MUL, PH_FMUL:
                if (mul_last)
                begin
                    fin     = 1'b1;
                    phase_n = PH_IDLE;
                end
            PH_SQR:
                if (mul_last)
                begin
                    mul_load = 1'b1;
                    if (exp_bit)
                    begin
                        ld_b    = base;
                        phase_n = PH_EXPM;
                    end
                    else if (exp_last)
                    begin
                        ld_b    = numer;
                        phase_n = PH_FMUL;
                    end
                    else
                        exp_step = 1'b1;
                end
            PH_EXPM:
                if (mul_last)
                begin
                    mul_load = 1'b1;
                    if (exp_last)
                    begin
                        ld_b    = numer;  // a * b^(p-2)
                        phase_n = PH_FMUL;
                    end
                    else
                    begin
                        exp_step = 1'b1;
                        phase_n  = PH_SQR;
                    end
                end
            default:
                phase_n = PH_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            phase    <= PH_IDLE;
            alu.done <= 1'b0;
        end
        else
        begin
            phase    <= phase_n;
            alu.done <= fin;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (accept)
        begin
            base  <= alu.op_b;
            numer <= alu.op_a;
        end
        if (mul_load)
        begin
            mcand  <= ld_a;
            mplier <= ld_b;
            acc    <= '0;
        end
        else if (mul_run)
            acc <= acc_next;
        if (fin)
            alu.result <= fin_val;
    end

    a_result_reduced: assert property (@(posedge i_clk) disable iff (i_reset)
        alu.done |-> (alu.result < field_pkg::field_prime));

endmodule

//--- hdl/field_op_if.sv
`timescale 1ns/1ps

interface field_op_if;

    logic                 req;
    field_pkg::field_op_e opcode;
    field_pkg::field_t    op_a;
    field_pkg::field_t    op_b;
    logic                 done;     // one-cycle pulse
    field_pkg::field_t    result;

    modport seq (
        output req, opcode, op_a, op_b,
        input  done, result
    );

    modport alu (
        input  req, opcode, op_a, op_b,
        output done, result
    );

endinterface

//--- hdl/field_pkg.sv
package field_pkg;

    localparam int field_w = 32;

    typedef logic [field_w-1:0] field_t;
    typedef logic [4:0] bit_idx_t;

    localparam field_t field_prime = 32'hFFFF_FFFB;            // 4294967291
    localparam field_t field_inv_exp = field_prime - field_t'(2);  // fermat inverse

    typedef enum logic [1:0] {
        FOP_ADD,
        FOP_SUB,
        FOP_MUL,
        FOP_DIV
    } field_op_e;

endpackage

//--- hdl/point_ctl_if.sv
`timescale 1ns/1ps

interface point_ctl_if;

    logic                 load;
    point_pkg::opnd_src_e src_a;
    point_pkg::opnd_src_e src_b;
    logic                 wr_en;
    point_pkg::dst_e      wr_dst;
    field_pkg::field_t    opnd_a;
    field_pkg::field_t    opnd_b;

    modport seq (output load, src_a, src_b, wr_en, wr_dst, input opnd_a, opnd_b);
    modport regs (input load, src_a, src_b, wr_en, wr_dst, output opnd_a, opnd_b);

endinterface

//--- hdl/point_pkg.sv
package point_pkg;

    typedef enum logic {
        PT_DOUBLE,
        PT_ADD
    } point_op_e;

    typedef enum logic [4:0] {
        S_IDLE,
        S_D1, S_D2, S_D3, S_D4, S_D5, S_D6,
        S_D7, S_D8, S_D9, S_D10, S_D11,
        S_A1, S_A2, S_A3, S_A4, S_A5,
        S_A6, S_A7, S_A8, S_A9,
        S_DONE
    } seq_state_e;

    typedef enum logic [2:0] {
        SRC_X1, SRC_Y1, SRC_X2, SRC_Y2,
        SRC_A, SRC_R1, SRC_R2, SRC_X3
    } opnd_src_e;

    typedef enum logic [2:0] {
        DST_R1, DST_R2, DST_X3, DST_Y3
    } dst_e;

endpackage

//--- hdl/point_regs.sv
`timescale 1ns/1ps

module point_regs (
    input  logic              i_clk,
    input  logic              i_reset,
    input  field_pkg::field_t i_x1,
    input  field_pkg::field_t i_y1,
    input  field_pkg::field_t i_x2,
    input  field_pkg::field_t i_y2,
    input  field_pkg::field_t i_a,
    input  field_pkg::field_t i_result,
    point_ctl_if.regs         ctl,
    output field_pkg::field_t o_x3,
    output field_pkg::field_t o_y3
);

    field_pkg::field_t x1, y1, x2, y2, a, r1, r2, x3, y3;

    function automatic field_pkg::field_t pick(input point_pkg::opnd_src_e src);
        case (src)
            point_pkg::SRC_X1: pick = x1;
            point_pkg::SRC_Y1: pick = y1;
            point_pkg::SRC_X2: pick = x2;
            point_pkg::SRC_Y2: pick = y2;
            point_pkg::SRC_A:  pick = a;
            point_pkg::SRC_R1: pick = r1;
            point_pkg::SRC_R2: pick = r2;
            point_pkg::SRC_X3: pick = x3;
            default:           pick = '0;
        endcase
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (ctl.load)
        begin
            x1 <= i_x1;
            y1 <= i_y1;
            x2 <= i_x2;
            y2 <= i_y2;
            a  <= i_a;
        end
        if (ctl.wr_en && ctl.wr_dst == point_pkg::DST_R1)
            r1 <= i_result;
        if (ctl.wr_en && ctl.wr_dst == point_pkg::DST_R2)
            r2 <= i_result;
    end

    // x3 doubles as scratch during doubling
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            x3 <= '0;
            y3 <= '0;
        end
        else
        begin
            if (ctl.wr_en && ctl.wr_dst == point_pkg::DST_X3)
                x3 <= i_result;
            if (ctl.wr_en && ctl.wr_dst == point_pkg::DST_Y3)
                y3 <= i_result;
        end
    end

    always_comb
    begin
        ctl.opnd_a = pick(ctl.src_a);
        ctl.opnd_b = pick(ctl.src_b);
    end

    assign o_x3 = x3;
    assign o_y3 = y3;

endmodule

//--- hdl/point_seq_fsm.sv
`timescale 1ns/1ps

module point_seq_fsm (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_start,
    input  point_pkg::point_op_e i_point_op,
    output logic                 o_busy,
    output logic                 o_done,
    field_op_if.seq              fop,
    point_ctl_if.seq             ctl
);

    typedef struct packed {
        field_pkg::field_op_e  op;
        point_pkg::opnd_src_e  src_a;
        point_pkg::opnd_src_e  src_b;
        point_pkg::dst_e       dst;
        point_pkg::seq_state_e nxt;
    } step_t;

    point_pkg::seq_state_e state;
    step_t                 stp;
    logic                  req_q, accept;

    function automatic step_t mk(input field_pkg::field_op_e op,
                                 input point_pkg::opnd_src_e a,
                                 input point_pkg::opnd_src_e b,
                                 input point_pkg::dst_e d,
                                 input point_pkg::seq_state_e n);
        return '{op: op, src_a: a, src_b: b, dst: d, nxt: n};
    endfunction

    // doubling keeps 2*x1 in x3 until the slope is known
    always_comb
    begin
        case (state)
            point_pkg::S_D1:
                stp = mk(field_pkg::FOP_ADD, point_pkg::SRC_X1, point_pkg::SRC_X1,
                         point_pkg::DST_X3, point_pkg::S_D2);
            point_pkg::S_D2:
                stp = mk(field_pkg::FOP_ADD, point_pkg::SRC_X3, point_pkg::SRC_X1,
                         point_pkg::DST_R1, point_pkg::S_D3);
            point_pkg::S_D3:
                stp = mk(field_pkg::FOP_MUL, point_pkg::SRC_R1, point_pkg::SRC_X1,
                         point_pkg::DST_R1, point_pkg::S_D4);  // 3*x1^2
            point_pkg::S_D4:
                stp = mk(field_pkg::FOP_ADD, point_pkg::SRC_R1, point_pkg::SRC_A,
                         point_pkg::DST_R1, point_pkg::S_D5);
            point_pkg::S_D5:
                stp = mk(field_pkg::FOP_ADD, point_pkg::SRC_Y1, point_pkg::SRC_Y1,
                         point_pkg::DST_R2, point_pkg::S_D6);
            point_pkg::S_D6:
                stp = mk(field_pkg::FOP_DIV, point_pkg::SRC_R1, point_pkg::SRC_R2,
                         point_pkg::DST_R1, point_pkg::S_D7);  // slope
            point_pkg::S_D7:
                stp = mk(field_pkg::FOP_MUL, point_pkg::SRC_R1, point_pkg::SRC_R1,
                         point_pkg::DST_R2, point_pkg::S_D8);
            point_pkg::S_D8:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_R2, point_pkg::SRC_X3,
                         point_pkg::DST_X3, point_pkg::S_D9);
            point_pkg::S_D9:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_X1, point_pkg::SRC_X3,
                         point_pkg::DST_R2, point_pkg::S_D10);
            point_pkg::S_D10:
                stp = mk(field_pkg::FOP_MUL, point_pkg::SRC_R1, point_pkg::SRC_R2,
                         point_pkg::DST_R2, point_pkg::S_D11);
            point_pkg::S_D11:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_R2, point_pkg::SRC_Y1,
                         point_pkg::DST_Y3, point_pkg::S_DONE);
            point_pkg::S_A1:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_X2, point_pkg::SRC_X1,
                         point_pkg::DST_R1, point_pkg::S_A2);
            point_pkg::S_A2:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_Y2, point_pkg::SRC_Y1,
                         point_pkg::DST_R2, point_pkg::S_A3);
            point_pkg::S_A3:
                stp = mk(field_pkg::FOP_DIV, point_pkg::SRC_R2, point_pkg::SRC_R1,
                         point_pkg::DST_R1, point_pkg::S_A4);  // slope
            point_pkg::S_A4:
                stp = mk(field_pkg::FOP_MUL, point_pkg::SRC_R1, point_pkg::SRC_R1,
                         point_pkg::DST_R2, point_pkg::S_A5);
            point_pkg::S_A5:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_R2, point_pkg::SRC_X1,
                         point_pkg::DST_R2, point_pkg::S_A6);
            point_pkg::S_A6:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_R2, point_pkg::SRC_X2,
                         point_pkg::DST_X3, point_pkg::S_A7);
            point_pkg::S_A7:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_X1, point_pkg::SRC_X3,
                         point_pkg::DST_R2, point_pkg::S_A8);
            point_pkg::S_A8:
                stp = mk(field_pkg::FOP_MUL, point_pkg::SRC_R1, point_pkg::SRC_R2,
                         point_pkg::DST_R2, point_pkg::S_A9);
            point_pkg::S_A9:
                stp = mk(field_pkg::FOP_SUB, point_pkg::SRC_R2, point_pkg::SRC_Y1,
                         point_pkg::DST_Y3, point_pkg::S_DONE);
            default:
                stp = mk(field_pkg::FOP_ADD, point_pkg::SRC_X1, point_pkg::SRC_X1,
                         point_pkg::DST_R1, point_pkg::S_IDLE);
        endcase
    end

    assign o_busy = (state != point_pkg::S_IDLE) && (state != point_pkg::S_DONE);
    assign o_done = (state == point_pkg::S_DONE);
    assign accept = i_start && !o_busy;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state <= point_pkg::S_IDLE;
            req_q <= 1'b0;
        end
        else if (accept)
            state <= (i_point_op == point_pkg::PT_DOUBLE) ? point_pkg::S_D1 : point_pkg::S_A1;
        else if (o_done)
            state <= point_pkg::S_IDLE;
        else if (o_busy)
        begin
            if (fop.done)
            begin
                state <= stp.nxt;
                req_q <= 1'b0;  // one idle cycle between steps
            end
            else
                req_q <= 1'b1;
        end
    end

    assign fop.req    = req_q;
    assign fop.opcode = stp.op;
    assign fop.op_a   = ctl.opnd_a;
    assign fop.op_b   = ctl.opnd_b;

    assign ctl.load   = accept;
    assign ctl.src_a  = stp.src_a;
    assign ctl.src_b  = stp.src_b;
    assign ctl.wr_en  = req_q && fop.done;
    assign ctl.wr_dst = stp.dst;

    a_req_held: assert property (@(posedge i_clk) disable iff (i_reset)
        fop.req && !fop.done |=> fop.req && $stable(fop.opcode)
            && $stable(fop.op_a) && $stable(fop.op_b));

endmodule

//--- vlog.f
hdl/field_pkg.sv
hdl/point_pkg.sv
hdl/field_op_if.sv
hdl/point_ctl_if.sv
hdl/bit_counter.sv
hdl/field_alu.sv
hdl/point_regs.sv
hdl/point_seq_fsm.sv
hdl/ec_point_unit.sv
bench/tb_ec_point_unit.sv
